// ==== design/bridge_pkg.sv ====
package bridge_pkg;

  // bus widths
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int STRB_W  = DATA_W / 8;
  localparam int ID_W    = 4;
  localparam int LEN_W   = 8;   // AXI4 burst length field
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int RESP_W  = 2;

  // AXI field encodings
  localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;
  localparam logic [SIZE_W-1:0]  SIZE_WORD  = 3'b010;  // 4 bytes per beat

  // transaction ids, one per requester class
  localparam logic [ID_W-1:0] ID_FETCH = 4'd0;
  localparam logic [ID_W-1:0] ID_DATA  = 4'd1;

  // owner of the current read
  typedef enum logic {
    SRC_FETCH,
    SRC_DATA
  } req_src_e;

  // arbiter control states
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_READ,
    ARB_WRITE,
    ARB_RELEASE   // one spare cycle so the requester can drop its valid
  } arb_state_e;

endpackage

// ==== design/bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter import bridge_pkg::*; (
  input  logic              clk,
  input  logic              arst_n_i,
  // fetch read requester
  input  logic              fetch_rvalid_i,
  input  logic [ADDR_W-1:0] fetch_raddr_i,
  input  logic [LEN_W-1:0]  fetch_rlen_i,
  // data read requester
  input  logic              data_rvalid_i,
  input  logic [ADDR_W-1:0] data_raddr_i,
  // data write requester
  input  logic              data_wvalid_i,
  // from the channel engines
  input  logic              beat_valid_i,
  input  logic              beat_last_i,
  input  logic              rd_done_i,
  input  logic              wr_done_i,
  // to the read engine
  output logic              rd_start_o,
  output req_src_e          rd_src_o,
  output logic [ADDR_W-1:0] rd_addr_o,
  output logic [LEN_W-1:0]  rd_len_o,
  // to the write engine
  output logic              wr_start_o,
  // completion pulses back to requesters
  output logic              fetch_rdata_ready_o,
  output logic              data_rdata_ready_o,
  output logic              data_wdone_o
);

  arb_state_e        state_q;
  arb_state_e        state_d;
  logic              grant_wr;
  logic              grant_rd;
  logic              rd_start_q;
  logic              wr_start_q;
  req_src_e          src_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  len_q;

  // fixed priority: write, then data read, then fetch
  assign grant_wr = (state_q == ARB_IDLE) && data_wvalid_i;
  assign grant_rd = (state_q == ARB_IDLE) && !data_wvalid_i &&
                    (data_rvalid_i || fetch_rvalid_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB_IDLE: begin
        if (grant_wr) begin
          state_d = ARB_WRITE;
        end else if (grant_rd) begin
          state_d = ARB_READ;
        end
      end
      ARB_READ: begin
        if (rd_done_i) state_d = ARB_RELEASE;   // last beat delivered
      end
      ARB_WRITE: begin
        if (wr_done_i) state_d = ARB_RELEASE;
      end
      ARB_RELEASE: state_d = ARB_IDLE;
      default:     state_d = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= ARB_IDLE;
      rd_start_q <= 1'b0;
      wr_start_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      rd_start_q <= grant_rd;  // start one cycle after the decision
      wr_start_q <= grant_wr;
    end
  end

  // winning read request, held for the engine
  always_ff @(posedge clk) begin
    if (grant_rd) begin
      if (data_rvalid_i) begin
        src_q  <= SRC_DATA;
        addr_q <= data_raddr_i;
        len_q  <= '0;            // data reads are single beat
      end else begin
        src_q  <= SRC_FETCH;
        addr_q <= fetch_raddr_i;
        len_q  <= fetch_rlen_i;
      end
    end
  end

  assign rd_start_o = rd_start_q;
  assign wr_start_o = wr_start_q;
  assign rd_src_o   = src_q;
  assign rd_addr_o  = addr_q;
  assign rd_len_o   = len_q;

  // steer engine pulses to the owner
  assign fetch_rdata_ready_o = (state_q == ARB_READ) && (src_q == SRC_FETCH) &&
                               beat_valid_i;
  assign data_rdata_ready_o  = (state_q == ARB_READ) && (src_q == SRC_DATA) &&
                               beat_valid_i && beat_last_i;
  assign data_wdone_o        = (state_q == ARB_WRITE) && wr_done_i;

endmodule

// ==== design/axi_read_channel.sv ====
`timescale 1ns/100ps

module axi_read_channel import bridge_pkg::*; (
  input  logic               clk,
  input  logic               arst_n_i,
  // request from the arbiter
  input  logic               rd_start_i,
  input  req_src_e           rd_src_i,
  input  logic [ADDR_W-1:0]  rd_addr_i,
  input  logic [LEN_W-1:0]   rd_len_i,
  // AR channel
  input  logic               axi_ar_ready_i,
  output logic               axi_ar_valid_o,
  output logic [ADDR_W-1:0]  axi_ar_addr_o,
  output logic [ID_W-1:0]    axi_ar_id_o,
  output logic [LEN_W-1:0]   axi_ar_len_o,
  output logic [SIZE_W-1:0]  axi_ar_size_o,
  output logic [BURST_W-1:0] axi_ar_burst_o,
  // R channel
  input  logic               axi_r_valid_i,
  input  logic [DATA_W-1:0]  axi_r_data_i,
  input  logic               axi_r_last_i,
  input  logic [RESP_W-1:0]  axi_r_resp_i,
  input  logic [ID_W-1:0]    axi_r_id_i,
  output logic               axi_r_ready_o,
  // beats back to the arbiter
  output logic               beat_valid_o,
  output logic [DATA_W-1:0]  beat_data_o,
  output logic               beat_last_o,
  output logic               rd_done_o
);

  logic ar_hs;
  logic r_hs;

  assign ar_hs = axi_ar_valid_o && axi_ar_ready_i;
  assign r_hs  = axi_r_valid_i && axi_r_ready_o;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      axi_ar_valid_o <= 1'b0;
      axi_r_ready_o  <= 1'b0;
      beat_valid_o   <= 1'b0;
      beat_last_o    <= 1'b0;
    end else begin
      if (rd_start_i) begin
        axi_ar_valid_o <= 1'b1;
      end else if (ar_hs) begin
        axi_ar_valid_o <= 1'b0;
      end
      // open for data from start until the last beat
      if (rd_start_i) begin
        axi_r_ready_o <= 1'b1;
      end else if (r_hs && axi_r_last_i) begin
        axi_r_ready_o <= 1'b0;
      end
      beat_valid_o <= r_hs;
      if (r_hs) beat_last_o <= axi_r_last_i;
    end
  end

  // request payload, stable while arvalid is up
  always_ff @(posedge clk) begin
    if (rd_start_i) begin
      axi_ar_addr_o <= rd_addr_i;
      axi_ar_len_o  <= rd_len_i;
      axi_ar_id_o   <= (rd_src_i == SRC_FETCH) ? ID_FETCH : ID_DATA;
    end
    if (r_hs) beat_data_o <= axi_r_data_i;
  end

  assign axi_ar_size_o  = SIZE_WORD;
  assign axi_ar_burst_o = BURST_INCR;

  // one read in flight, so rid and rresp carry nothing for the requester
  assign rd_done_o = beat_valid_o && beat_last_o;

endmodule

// ==== design/axi_write_channel.sv ====
`timescale 1ns/100ps

module axi_write_channel import bridge_pkg::*; (
  input  logic               clk,
  input  logic               arst_n_i,
  // request from the arbiter and the data requester
  input  logic               wr_start_i,
  input  logic [ADDR_W-1:0]  wr_addr_i,
  input  logic [DATA_W-1:0]  wr_data_i,
  input  logic [STRB_W-1:0]  wr_mask_i,
  // AW channel
  input  logic               axi_aw_ready_i,
  output logic               axi_aw_valid_o,
  output logic [ADDR_W-1:0]  axi_aw_addr_o,
  output logic [ID_W-1:0]    axi_aw_id_o,
  output logic [LEN_W-1:0]   axi_aw_len_o,
  output logic [SIZE_W-1:0]  axi_aw_size_o,
  output logic [BURST_W-1:0] axi_aw_burst_o,
  // W channel
  input  logic               axi_w_ready_i,
  output logic               axi_w_valid_o,
  output logic [DATA_W-1:0]  axi_w_data_o,
  output logic [STRB_W-1:0]  axi_w_strb_o,
  output logic               axi_w_last_o,
  // B channel
  input  logic               axi_b_valid_i,
  input  logic [RESP_W-1:0]  axi_b_resp_i,
  input  logic [ID_W-1:0]    axi_b_id_i,
  output logic               axi_b_ready_o,
  // completion
  output logic               wr_done_o
);

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic aw_done_q;   // address accepted
  logic w_done_q;    // data accepted
  logic aw_ok;
  logic w_ok;

  assign aw_hs = axi_aw_valid_o && axi_aw_ready_i;
  assign w_hs  = axi_w_valid_o && axi_w_ready_i;
  assign b_hs  = axi_b_valid_i && axi_b_ready_o;

  // either channel may finish first
  assign aw_ok = aw_done_q || aw_hs;
  assign w_ok  = w_done_q || w_hs;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      axi_aw_valid_o <= 1'b0;
      axi_w_valid_o  <= 1'b0;
      axi_b_ready_o  <= 1'b0;
      aw_done_q      <= 1'b0;
      w_done_q       <= 1'b0;
      wr_done_o      <= 1'b0;
    end else begin
      wr_done_o <= b_hs;
      if (wr_start_i) begin
        axi_aw_valid_o <= 1'b1;   // aw and w go up together
        axi_w_valid_o  <= 1'b1;
        aw_done_q      <= 1'b0;
        w_done_q       <= 1'b0;
      end else if (b_hs) begin
        axi_b_ready_o <= 1'b0;
        aw_done_q     <= 1'b0;
        w_done_q      <= 1'b0;
      end else begin
        if (aw_hs) begin
          axi_aw_valid_o <= 1'b0;
          aw_done_q      <= 1'b1;
        end
        if (w_hs) begin
          axi_w_valid_o <= 1'b0;
          w_done_q      <= 1'b1;
        end
        if (aw_ok && w_ok) axi_b_ready_o <= 1'b1;  // now wait for bresp
      end
    end
  end

  // payload captured at start, held through both handshakes
  always_ff @(posedge clk) begin
    if (wr_start_i) begin
      axi_aw_addr_o <= wr_addr_i;
      axi_w_data_o  <= wr_data_i;
      axi_w_strb_o  <= wr_mask_i;
    end
  end

  // single beat, fixed attributes
  assign axi_aw_id_o    = ID_DATA;
  assign axi_aw_len_o   = '0;
  assign axi_aw_size_o  = SIZE_WORD;
  assign axi_aw_burst_o = BURST_INCR;
  assign axi_w_last_o   = 1'b1;

endmodule

// ==== design/mem_bridge_top.sv ====
`timescale 1ns/100ps

module mem_bridge_top import bridge_pkg::*; (
  input  logic               clk,
  input  logic               arst_n_i,
  // fetch read port
  input  logic [ADDR_W-1:0]  fetch_raddr_i,
  input  logic               fetch_rvalid_i,
  input  logic [LEN_W-1:0]   fetch_rlen_i,
  output logic [DATA_W-1:0]  fetch_rdata_o,
  output logic               fetch_rdata_ready_o,
  output logic               fetch_rlast_o,
  // data read port
  input  logic [ADDR_W-1:0]  data_raddr_i,
  input  logic               data_rvalid_i,
  output logic [DATA_W-1:0]  data_rdata_o,
  output logic               data_rdata_ready_o,
  // data write port
  input  logic [ADDR_W-1:0]  data_waddr_i,
  input  logic               data_wvalid_i,
  input  logic [DATA_W-1:0]  data_wdata_i,
  input  logic [STRB_W-1:0]  data_wmask_i,
  output logic               data_wdone_o,
  // AXI4 master, write address
  input  logic               axi_aw_ready_i,
  output logic               axi_aw_valid_o,
  output logic [ADDR_W-1:0]  axi_aw_addr_o,
  output logic [ID_W-1:0]    axi_aw_id_o,
  output logic [LEN_W-1:0]   axi_aw_len_o,
  output logic [SIZE_W-1:0]  axi_aw_size_o,
  output logic [BURST_W-1:0] axi_aw_burst_o,
  // write data
  input  logic               axi_w_ready_i,
  output logic               axi_w_valid_o,
  output logic [DATA_W-1:0]  axi_w_data_o,
  output logic [STRB_W-1:0]  axi_w_strb_o,
  output logic               axi_w_last_o,
  // write response
  input  logic               axi_b_valid_i,
  input  logic [RESP_W-1:0]  axi_b_resp_i,
  input  logic [ID_W-1:0]    axi_b_id_i,
  output logic               axi_b_ready_o,
  // read address
  input  logic               axi_ar_ready_i,
  output logic               axi_ar_valid_o,
  output logic [ADDR_W-1:0]  axi_ar_addr_o,
  output logic [ID_W-1:0]    axi_ar_id_o,
  output logic [LEN_W-1:0]   axi_ar_len_o,
  output logic [SIZE_W-1:0]  axi_ar_size_o,
  output logic [BURST_W-1:0] axi_ar_burst_o,
  // read data
  input  logic               axi_r_valid_i,
  input  logic [DATA_W-1:0]  axi_r_data_i,
  input  logic               axi_r_last_i,
  input  logic [RESP_W-1:0]  axi_r_resp_i,
  input  logic [ID_W-1:0]    axi_r_id_i,
  output logic               axi_r_ready_o
);

  logic              rd_start;
  req_src_e          rd_src;
  logic [ADDR_W-1:0] rd_addr;
  logic [LEN_W-1:0]  rd_len;
  logic              wr_start;
  logic              beat_valid;
  logic [DATA_W-1:0] beat_data;
  logic              beat_last;
  logic              rd_done;
  logic              wr_done;

  bus_arbiter u_arbiter (
    .clk                 (clk),
    .arst_n_i            (arst_n_i),
    .fetch_rvalid_i      (fetch_rvalid_i),
    .fetch_raddr_i       (fetch_raddr_i),
    .fetch_rlen_i        (fetch_rlen_i),
    .data_rvalid_i       (data_rvalid_i),
    .data_raddr_i        (data_raddr_i),
    .data_wvalid_i       (data_wvalid_i),
    .beat_valid_i        (beat_valid),
    .beat_last_i         (beat_last),
    .rd_done_i           (rd_done),
    .wr_done_i           (wr_done),
    .rd_start_o          (rd_start),
    .rd_src_o            (rd_src),
    .rd_addr_o           (rd_addr),
    .rd_len_o            (rd_len),
    .wr_start_o          (wr_start),
    .fetch_rdata_ready_o (fetch_rdata_ready_o),
    .data_rdata_ready_o  (data_rdata_ready_o),
    .data_wdone_o        (data_wdone_o)
  );

  axi_read_channel u_rd_chan (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .rd_start_i     (rd_start),
    .rd_src_i       (rd_src),
    .rd_addr_i      (rd_addr),
    .rd_len_i       (rd_len),
    .axi_ar_ready_i (axi_ar_ready_i),
    .axi_ar_valid_o (axi_ar_valid_o),
    .axi_ar_addr_o  (axi_ar_addr_o),
    .axi_ar_id_o    (axi_ar_id_o),
    .axi_ar_len_o   (axi_ar_len_o),
    .axi_ar_size_o  (axi_ar_size_o),
    .axi_ar_burst_o (axi_ar_burst_o),
    .axi_r_valid_i  (axi_r_valid_i),
    .axi_r_data_i   (axi_r_data_i),
    .axi_r_last_i   (axi_r_last_i),
    .axi_r_resp_i   (axi_r_resp_i),
    .axi_r_id_i     (axi_r_id_i),
    .axi_r_ready_o  (axi_r_ready_o),
    .beat_valid_o   (beat_valid),
    .beat_data_o    (beat_data),
    .beat_last_o    (beat_last),
    .rd_done_o      (rd_done)
  );

  // write payload comes straight from the data requester
  axi_write_channel u_wr_chan (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .wr_start_i     (wr_start),
    .wr_addr_i      (data_waddr_i),
    .wr_data_i      (data_wdata_i),
    .wr_mask_i      (data_wmask_i),
    .axi_aw_ready_i (axi_aw_ready_i),
    .axi_aw_valid_o (axi_aw_valid_o),
    .axi_aw_addr_o  (axi_aw_addr_o),
    .axi_aw_id_o    (axi_aw_id_o),
    .axi_aw_len_o   (axi_aw_len_o),
    .axi_aw_size_o  (axi_aw_size_o),
    .axi_aw_burst_o (axi_aw_burst_o),
    .axi_w_ready_i  (axi_w_ready_i),
    .axi_w_valid_o  (axi_w_valid_o),
    .axi_w_data_o   (axi_w_data_o),
    .axi_w_strb_o   (axi_w_strb_o),
    .axi_w_last_o   (axi_w_last_o),
    .axi_b_valid_i  (axi_b_valid_i),
    .axi_b_resp_i   (axi_b_resp_i),
    .axi_b_id_i     (axi_b_id_i),
    .axi_b_ready_o  (axi_b_ready_o),
    .wr_done_o      (wr_done)
  );

  // read data fans out to both requesters
  assign fetch_rdata_o = beat_data;
  assign data_rdata_o  = beat_data;
  assign fetch_rlast_o = beat_last;

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;   // 8 ns period
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule

// ==== verif/mem_bridge_assert.sv ====
`timescale 1ns/100ps

module mem_bridge_assert (
  input logic clk,
  input logic arst_n_i,
  input logic ar_valid_i,
  input logic ar_ready_i,
  input logic aw_valid_i,
  input logic aw_ready_i,
  input logic fetch_pulse_i,
  input logic data_pulse_i
);

  int fail_cnt = 0;   // read back by the testbench at the end

  ar_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      ar_valid_i && !ar_ready_i |=> ar_valid_i)
    else begin
      $error("arvalid dropped before arready");
      fail_cnt++;
    end

  aw_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      aw_valid_i && !aw_ready_i |=> aw_valid_i)
    else begin
      $error("awvalid dropped before awready");
      fail_cnt++;
    end

  // only one read owner at a time
  pulse_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
      !(fetch_pulse_i && data_pulse_i))
    else begin
      $error("fetch and data read pulses together");
      fail_cnt++;
    end

  addr_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
      !(ar_valid_i && aw_valid_i))
    else begin
      $error("arvalid and awvalid high together");
      fail_cnt++;
    end

endmodule

bind mem_bridge_top mem_bridge_assert u_assert (
  .clk           (clk),
  .arst_n_i      (arst_n_i),
  .ar_valid_i    (axi_ar_valid_o),
  .ar_ready_i    (axi_ar_ready_i),
  .aw_valid_i    (axi_aw_valid_o),
  .aw_ready_i    (axi_aw_ready_i),
  .fetch_pulse_i (fetch_rdata_ready_o),
  .data_pulse_i  (data_rdata_ready_o)
);

// ==== verif/tb_mem_bridge.sv ====
`timescale 1ns/100ps

module tb_mem_bridge import bridge_pkg::*; ();

  localparam logic [31:0] LFSR_SEED   = 32'h9b2d_5cc2;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
  localparam logic [31:0] FILL_XOR    = 32'ha5a5_0000;   // word at A is A ^ FILL_XOR
  localparam int          MEM_WORDS   = 1024;
  localparam int          TIMEOUT_CYC = 200;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } beat_t;

  typedef struct packed {
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
    logic [ID_W-1:0]    id;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
  } ar_rec_t;

  logic               clk;
  logic               arst_n_i;
  logic [ADDR_W-1:0]  fetch_raddr_i;
  logic [LEN_W-1:0]   fetch_rlen_i;
  logic               fetch_rvalid_i;
  logic [DATA_W-1:0]  fetch_rdata_o;
  logic               fetch_rdata_ready_o;
  logic               fetch_rlast_o;
  logic [ADDR_W-1:0]  data_raddr_i;
  logic               data_rvalid_i;
  logic [DATA_W-1:0]  data_rdata_o;
  logic               data_rdata_ready_o;
  logic [ADDR_W-1:0]  data_waddr_i;
  logic               data_wvalid_i;
  logic [DATA_W-1:0]  data_wdata_i;
  logic [STRB_W-1:0]  data_wmask_i;
  logic               data_wdone_o;
  logic               axi_aw_ready_i;
  logic               axi_aw_valid_o;
  logic [ADDR_W-1:0]  axi_aw_addr_o;
  logic [ID_W-1:0]    axi_aw_id_o;
  logic [LEN_W-1:0]   axi_aw_len_o;
  logic [SIZE_W-1:0]  axi_aw_size_o;
  logic [BURST_W-1:0] axi_aw_burst_o;
  logic               axi_w_ready_i;
  logic               axi_w_valid_o;
  logic [DATA_W-1:0]  axi_w_data_o;
  logic [STRB_W-1:0]  axi_w_strb_o;
  logic               axi_w_last_o;
  logic               axi_b_valid_i;
  logic [RESP_W-1:0]  axi_b_resp_i;
  logic [ID_W-1:0]    axi_b_id_i;
  logic               axi_b_ready_o;
  logic               axi_ar_ready_i;
  logic               axi_ar_valid_o;
  logic [ADDR_W-1:0]  axi_ar_addr_o;
  logic [ID_W-1:0]    axi_ar_id_o;
  logic [LEN_W-1:0]   axi_ar_len_o;
  logic [SIZE_W-1:0]  axi_ar_size_o;
  logic [BURST_W-1:0] axi_ar_burst_o;
  logic               axi_r_valid_i;
  logic [DATA_W-1:0]  axi_r_data_i;
  logic               axi_r_last_i;
  logic [RESP_W-1:0]  axi_r_resp_i;
  logic [ID_W-1:0]    axi_r_id_i;
  logic               axi_r_ready_o;

  logic [DATA_W-1:0] mem [MEM_WORDS];   // slave memory
  logic [DATA_W-1:0] ref_wr [logic [ADDR_W-1:0]];   // reference copy of written words
  beat_t             fetch_exp [$];
  beat_t             data_exp [$];
  ar_rec_t           ar_log [$];
  byte               ev_log [$];   // handshake order, W, D or F
  logic [31:0]       lfsr_q;
  int                ar_dly;
  int                r_dly;
  int                aw_dly;
  int                w_dly;
  int                b_dly;
  int                errs = 0;
  int                wdone_cnt = 0;
  int                tests_run = 0;
  int                tests_passed = 0;

  tb_clk_gen u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n_i)
  );

  mem_bridge_top UUT (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // two bits, one step each
  function automatic int rand_delay();
    int d;
    int i;
    d = 0;
    for (i = 0; i < 2; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      d = (d << 1) | lfsr_q[0];
    end
    return d;
  endfunction

  function automatic bit delay_done(ref int dly);
    if (dly == 0) return 1'b1;
    dly--;
    return 1'b0;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [STRB_W-1:0] mask);
    logic [31:0] res;
    int b;
    res = old_word;
    for (b = 0; b < STRB_W; b++) begin
      if (mask[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  // reference: fill rule unless a write landed there
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    if (ref_wr.exists(addr)) return ref_wr[addr];
    return addr ^ FILL_XOR;
  endfunction

  task automatic record_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [STRB_W-1:0] mask);
    ref_wr[addr] = merge_bytes(expected_word(addr), data, mask);
  endtask

  task automatic queue_fetch_beats(input logic [31:0] addr, input int len);
    int i;
    for (i = 0; i <= len; i++) begin
      fetch_exp.push_back('{data: expected_word(addr + 4 * i), last: (i == len)});
    end
  endtask

  task automatic queue_data_beat(input logic [31:0] addr);
    data_exp.push_back('{data: expected_word(addr), last: 1'b1});
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
      errs++;
    end
  endtask

  task automatic check_ar(input logic [31:0] addr, input int len, input logic [ID_W-1:0] id);
    ar_rec_t rec;
    assert (ar_log.size() == 1) else begin
      $display("expected one read address request but saw %0d", ar_log.size());
      errs++;
    end
    if (ar_log.size() == 1) begin
      rec = ar_log[0];
      compare_value("axi_ar_addr_o", rec.addr, addr);
      compare_value("axi_ar_len_o", rec.len, len);
      compare_value("axi_ar_id_o", rec.id, id);
      compare_value("axi_ar_size_o", rec.size, SIZE_WORD);
      compare_value("axi_ar_burst_o", rec.burst, BURST_INCR);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    assert (fetch_exp.size() == 0 && data_exp.size() == 0) else begin
      $display("%0d fetch and %0d data beats never arrived", fetch_exp.size(),
               data_exp.size());
      errs++;
    end
    fetch_exp.delete();
    data_exp.delete();
    tests_run++;
    if (errs == err_before) begin
      tests_passed++;
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests_run, name, errs - err_before);
    end
  endtask

  // requesters hold valid until the final pulse, then drop it
  task automatic fetch_burst(input logic [31:0] addr, input logic [LEN_W-1:0] len);
    bit seen;
    int n;
    @(posedge clk);
    #1;
    fetch_raddr_i  = addr;
    fetch_rlen_i   = len;
    fetch_rvalid_i = 1'b1;
    seen = 1'b0;
    for (n = 0; n < TIMEOUT_CYC && !seen; n++) begin
      @(posedge clk);
      seen = fetch_rdata_ready_o && fetch_rlast_o;
    end
    #1;
    fetch_rvalid_i = 1'b0;
    if (!seen) begin
      $display("fetch read at %h never finished", addr);
      errs++;
    end
  endtask

  task automatic read_data_word(input logic [31:0] addr);
    bit seen;
    int n;
    @(posedge clk);
    #1;
    data_raddr_i  = addr;
    data_rvalid_i = 1'b1;
    seen = 1'b0;
    for (n = 0; n < TIMEOUT_CYC && !seen; n++) begin
      @(posedge clk);
      seen = data_rdata_ready_o;
    end
    #1;
    data_rvalid_i = 1'b0;
    if (!seen) begin
      $display("data read at %h never finished", addr);
      errs++;
    end
  endtask

  task automatic write_data_word(input logic [31:0] addr, input logic [31:0] data,
                                 input logic [STRB_W-1:0] mask);
    bit seen;
    int n;
    @(posedge clk);
    #1;
    data_waddr_i  = addr;
    data_wdata_i  = data;
    data_wmask_i  = mask;
    data_wvalid_i = 1'b1;
    seen = 1'b0;
    for (n = 0; n < TIMEOUT_CYC && !seen; n++) begin
      @(posedge clk);
      seen = data_wdone_o;
    end
    #1;
    data_wvalid_i = 1'b0;
    if (!seen) begin
      $display("data write at %h never finished", addr);
      errs++;
    end
  endtask

  // AXI slave, read side
  always begin : rd_slave
    bit          ar_hs;
    bit          r_hs;
    logic [31:0] rd_ptr;
    logic [3:0]  rd_id;
    int          rd_left;
    @(posedge clk);
    ar_hs = axi_ar_ready_i && axi_ar_valid_o;
    r_hs  = axi_r_valid_i && axi_r_ready_o;
    if (ar_hs) begin
      ar_log.push_back('{axi_ar_addr_o, axi_ar_len_o, axi_ar_id_o, axi_ar_size_o,
                         axi_ar_burst_o});
      ev_log.push_back((axi_ar_id_o == ID_FETCH) ? "F" : "D");
      rd_ptr  = axi_ar_addr_o;
      rd_id   = axi_ar_id_o;
      rd_left = axi_ar_len_o + 1;
      ar_dly  = rand_delay();
      r_dly   = rand_delay();
    end
    if (r_hs) begin
      rd_ptr  = rd_ptr + 4;   // incrementing burst
      rd_left = rd_left - 1;
      r_dly   = rand_delay();
    end
    #1;
    if (ar_hs) begin
      axi_ar_ready_i = 1'b0;
    end else if (axi_ar_valid_o && !axi_ar_ready_i && rd_left == 0) begin
      if (delay_done(ar_dly)) axi_ar_ready_i = 1'b1;
    end
    if (r_hs) axi_r_valid_i = 1'b0;
    if (rd_left > 0 && !axi_r_valid_i && delay_done(r_dly)) begin
      axi_r_valid_i = 1'b1;
      axi_r_data_i  = mem[rd_ptr[11:2]];
      axi_r_last_i  = (rd_left == 1);
      axi_r_id_i    = rd_id;
    end
  end

  // AXI slave, write side; aw and w are taken in any order
  always begin : wr_slave
    bit          aw_hs;
    bit          w_hs;
    bit          b_hs;
    bit          aw_got;
    bit          w_got;
    bit          b_pend;
    logic [31:0] wr_ptr;
    logic [31:0] wr_word;
    logic [3:0]  wr_strb;
    int          b;
    @(posedge clk);
    aw_hs = axi_aw_ready_i && axi_aw_valid_o;
    w_hs  = axi_w_ready_i && axi_w_valid_o;
    b_hs  = axi_b_valid_i && axi_b_ready_o;
    if (aw_hs) begin
      ev_log.push_back("W");
      // data writes are single word beats on the data id
      compare_value("axi_aw_id_o", axi_aw_id_o, ID_DATA);
      compare_value("axi_aw_len_o", axi_aw_len_o, 0);
      compare_value("axi_aw_size_o", axi_aw_size_o, SIZE_WORD);
      compare_value("axi_aw_burst_o", axi_aw_burst_o, BURST_INCR);
      wr_ptr = axi_aw_addr_o;
      aw_got = 1'b1;
      aw_dly = rand_delay();
    end
    if (w_hs) begin
      compare_value("axi_w_last_o", axi_w_last_o, 1);
      wr_word = axi_w_data_o;
      wr_strb = axi_w_strb_o;
      w_got   = 1'b1;
      w_dly   = rand_delay();
    end
    if (aw_got && w_got) begin
      for (b = 0; b < STRB_W; b++) begin
        if (wr_strb[b]) mem[wr_ptr[11:2]][8*b +: 8] = wr_word[8*b +: 8];
      end
      aw_got = 1'b0;
      w_got  = 1'b0;
      b_pend = 1'b1;
      b_dly  = rand_delay();
    end
    #1;
    if (aw_hs) begin
      axi_aw_ready_i = 1'b0;
    end else if (axi_aw_valid_o && !axi_aw_ready_i) begin
      if (delay_done(aw_dly)) axi_aw_ready_i = 1'b1;
    end
    if (w_hs) begin
      axi_w_ready_i = 1'b0;
    end else if (axi_w_valid_o && !axi_w_ready_i) begin
      if (delay_done(w_dly)) axi_w_ready_i = 1'b1;
    end
    if (b_hs) begin
      axi_b_valid_i = 1'b0;
      b_pend        = 1'b0;
    end else if (b_pend && !axi_b_valid_i) begin
      if (delay_done(b_dly)) axi_b_valid_i = 1'b1;
    end
  end

  // compare every returned beat against the queued expectation
  always @(posedge clk) begin : compare_beats
    beat_t exp_beat;
    if (fetch_rdata_ready_o) begin
      assert (fetch_exp.size() != 0) else begin
        $display("fetch beat arrived with none expected at %0t", $time);
        errs++;
      end
      if (fetch_exp.size() != 0) begin
        exp_beat = fetch_exp.pop_front();
        compare_value("fetch_rdata_o", fetch_rdata_o, exp_beat.data);
        compare_value("fetch_rlast_o", fetch_rlast_o, exp_beat.last);
      end
    end
    if (data_rdata_ready_o) begin
      assert (data_exp.size() != 0) else begin
        $display("data read beat arrived with none expected at %0t", $time);
        errs++;
      end
      if (data_exp.size() != 0) begin
        exp_beat = data_exp.pop_front();
        compare_value("data_rdata_o", data_rdata_o, exp_beat.data);
      end
    end
    if (data_wdone_o) wdone_cnt++;
  end

  initial begin : main
    int err_before;
    int wd_before;
    int n;
    int i;
    int assert_fails;
    lfsr_q = LFSR_SEED;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (i * 4) ^ FILL_XOR;
    end
    ar_dly = rand_delay();
    r_dly  = rand_delay();
    aw_dly = rand_delay();
    w_dly  = rand_delay();
    b_dly  = rand_delay();
    fetch_raddr_i  = '0;
    fetch_rlen_i   = '0;
    fetch_rvalid_i = 1'b0;
    data_raddr_i   = '0;
    data_rvalid_i  = 1'b0;
    data_waddr_i   = '0;
    data_wvalid_i  = 1'b0;
    data_wdata_i   = '0;
    data_wmask_i   = '0;
    axi_aw_ready_i = 1'b0;
    axi_w_ready_i  = 1'b0;
    axi_b_valid_i  = 1'b0;
    axi_b_resp_i   = '0;
    axi_b_id_i     = ID_DATA;
    axi_ar_ready_i = 1'b0;
    axi_r_valid_i  = 1'b0;
    axi_r_data_i   = '0;
    axi_r_last_i   = 1'b0;
    axi_r_resp_i   = '0;
    axi_r_id_i     = '0;

    n = 0;
    while (arst_n_i !== 1'b1 && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (arst_n_i !== 1'b1) begin
      $display("reset was never released");
      errs++;
    end

    err_before = errs;
    @(posedge clk);
    compare_value("axi_ar_valid_o", axi_ar_valid_o, 0);
    compare_value("axi_aw_valid_o", axi_aw_valid_o, 0);
    compare_value("axi_w_valid_o", axi_w_valid_o, 0);
    compare_value("axi_r_ready_o", axi_r_ready_o, 0);
    compare_value("axi_b_ready_o", axi_b_ready_o, 0);
    compare_value("fetch_rdata_ready_o", fetch_rdata_ready_o, 0);
    compare_value("data_rdata_ready_o", data_rdata_ready_o, 0);
    compare_value("data_wdone_o", data_wdone_o, 0);
    end_test("reset values", err_before);

    err_before = errs;
    ar_log.delete();
    queue_fetch_beats(32'h0000_0100, 0);
    fetch_burst(32'h0000_0100, 8'd0);
    check_ar(32'h0000_0100, 0, ID_FETCH);
    end_test("single fetch", err_before);

    err_before = errs;
    ar_log.delete();
    queue_fetch_beats(32'h0000_0180, 7);
    fetch_burst(32'h0000_0180, 8'd7);
    check_ar(32'h0000_0180, 7, ID_FETCH);
    end_test("fetch burst of 8", err_before);

    err_before = errs;
    wd_before  = wdone_cnt;
    record_write(32'h0000_0200, 32'h1122_3344, 4'b0101);
    write_data_word(32'h0000_0200, 32'h1122_3344, 4'b0101);
    queue_data_beat(32'h0000_0200);
    read_data_word(32'h0000_0200);
    compare_value("data_wdone_o pulses", wdone_cnt - wd_before, 1);
    end_test("masked write then read", err_before);

    // all three raised in the same cycle
    err_before = errs;
    record_write(32'h0000_0300, 32'hdead_beef, 4'b1100);
    queue_data_beat(32'h0000_0300);
    queue_fetch_beats(32'h0000_0340, 3);
    ev_log.delete();
    fork
      write_data_word(32'h0000_0300, 32'hdead_beef, 4'b1100);
      read_data_word(32'h0000_0300);
      fetch_burst(32'h0000_0340, 8'd3);
    join
    assert (ev_log.size() == 3 && ev_log[0] == "W" && ev_log[1] == "D" &&
            ev_log[2] == "F") else begin
      $display("requests were not served as write, data read, fetch read");
      errs++;
    end
    end_test("priority order", err_before);

    assert_fails = UUT.u_assert.fail_cnt;
    errs = errs + assert_fails;
    $display("tests run %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_passed, tests_run - tests_passed, errs, assert_fails);
    if (errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
design/bridge_pkg.sv
design/bus_arbiter.sv
design/axi_read_channel.sv
design/axi_write_channel.sv
design/mem_bridge_top.sv
verif/tb_clk_gen.sv
verif/mem_bridge_assert.sv
verif/tb_mem_bridge.sv
